// ==== fetch_pkg.sv ====
package fetch_pkg;

    // datapath widths
    localparam int unsigned XLEN      = 32;
    localparam int unsigned REG_IDX_W = 5;

    // instruction queue sizing, depth must be a power of two
    localparam int unsigned IQ_ENTRIES = 8;
    localparam int unsigned IQ_PTR_W   = $clog2(IQ_ENTRIES);

    // first fetch address out of reset
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // major opcodes that pick the immediate format
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // one instruction word, seen through each base format
    typedef union packed {
        logic [XLEN-1:0] raw;
        struct packed {
            logic [6:0]           funct7;
            logic [REG_IDX_W-1:0] rs2;
            logic [REG_IDX_W-1:0] rs1;
            logic [2:0]           funct3;
            logic [REG_IDX_W-1:0] rd;
            logic [6:0]           opcode;
        } r;
        struct packed {
            logic [11:0]          imm_11_0;
            logic [REG_IDX_W-1:0] rs1;
            logic [2:0]           funct3;
            logic [REG_IDX_W-1:0] rd;
            logic [6:0]           opcode;
        } i;
        struct packed {
            logic [6:0]           imm_11_5;
            logic [REG_IDX_W-1:0] rs2;
            logic [REG_IDX_W-1:0] rs1;
            logic [2:0]           funct3;
            logic [4:0]           imm_4_0;
            logic [6:0]           opcode;
        } s;
        struct packed {
            logic                 imm_12;
            logic [5:0]           imm_10_5;
            logic [REG_IDX_W-1:0] rs2;
            logic [REG_IDX_W-1:0] rs1;
            logic [2:0]           funct3;
            logic [3:0]           imm_4_1;
            logic                 imm_11;
            logic [6:0]           opcode;
        } b;
        struct packed {
            logic [19:0]          imm_31_12;
            logic [REG_IDX_W-1:0] rd;
            logic [6:0]           opcode;
        } u;
        struct packed {
            logic                 imm_20;
            logic [9:0]           imm_10_1;
            logic                 imm_11;
            logic [7:0]           imm_19_12;
            logic [REG_IDX_W-1:0] rd;
            logic [6:0]           opcode;
        } j;
    } rv32i_instr_u;

endpackage : fetch_pkg

// ==== ifetch.sv ====
`timescale 1ns/10ps

module ifetch
    import fetch_pkg::*;
(
    input  logic            i_rst_n,
    input  logic            clk,
    input  logic            i_flush,
    input  logic [XLEN-1:0] i_redirect_pc,
    // wishbone classic master
    input  logic [XLEN-1:0] i_wb_dat,
    input  logic            i_wb_ack,
    output logic            o_wb_cyc,
    output logic            o_wb_stb,
    output logic [XLEN-1:0] o_wb_adr,
    output logic            o_wb_we,
    output logic [3:0]      o_wb_sel,
    // queue write side
    input  logic            i_full,
    output logic            o_push,
    output logic [XLEN-1:0] o_push_pc,
    output logic [XLEN-1:0] o_push_next_pc,
    output logic [XLEN-1:0] o_push_instr
);

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] redirect_aligned;
    logic            busy;
    logic            start;
    logic            done;

    assign pc_plus4 = pc + XLEN'(4);

    // fetch is word based, low bits of a redirect are ignored
    assign redirect_aligned = {i_redirect_pc[XLEN-1:2], 2'b00};

    // ack only counts while a cycle is open and no flush is in progress
    assign done = busy && i_wb_ack && !i_flush;

    // one request at a time, and only if the queue can take the word
    assign start = !busy && !i_full;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            pc   <= RESET_PC;
            busy <= 1'b0;
        end else if (i_flush) begin
            // abandon the open cycle, restart at the new address
            pc   <= redirect_aligned;
            busy <= 1'b0;
        end else if (done) begin
            pc   <= pc_plus4;
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end
    end

    // bus side
    assign o_wb_cyc = busy;
    assign o_wb_stb = busy;
    assign o_wb_adr = pc;
    // read only master
    assign o_wb_we  = 1'b0;
    assign o_wb_sel = 4'hf;

    // queue push in the ack cycle
    assign o_push         = done;
    assign o_push_pc      = pc;
    assign o_push_next_pc = pc_plus4;
    assign o_push_instr   = i_wb_dat;

    // an open request keeps stb and address until ack or flush
    property p_req_hold;
        @(posedge clk) disable iff (!i_rst_n)
            (o_wb_stb && !i_wb_ack && !i_flush) |=> (o_wb_stb && $stable(o_wb_adr));
    endproperty

    a_req_hold: assert property (p_req_hold)
        else $error("ifetch: wishbone request dropped or address changed before ack");

endmodule : ifetch

// ==== i_queue.sv ====
`timescale 1ns/10ps

module i_queue
    import fetch_pkg::*;
(
    input  logic            clk,
    input  logic            i_rst_n,
    input  logic            i_flush,
    // write side from fetch
    input  logic            i_push,
    input  logic [XLEN-1:0] i_push_pc,
    input  logic [XLEN-1:0] i_push_next_pc,
    input  logic [XLEN-1:0] i_push_instr,
    // read side to decode
    input  logic            i_pop,
    output logic [XLEN-1:0] o_head_pc,
    output logic [XLEN-1:0] o_head_next_pc,
    output logic [XLEN-1:0] o_head_instr,
    output logic            o_empty,
    output logic            o_full
);

    // entry storage, one array per field
    logic [XLEN-1:0]     pc_mem      [IQ_ENTRIES];
    logic [XLEN-1:0]     next_pc_mem [IQ_ENTRIES];
    logic [XLEN-1:0]     instr_mem   [IQ_ENTRIES];

    logic [IQ_PTR_W-1:0] head_ptr;
    logic [IQ_PTR_W-1:0] tail_ptr;
    logic [IQ_PTR_W:0]   count;
    logic                do_push;
    logic                do_pop;

    assign o_empty = (count == '0);
    // count never exceeds the depth, so the top bit alone means full
    assign o_full  = count[IQ_PTR_W];

    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            pc_mem[tail_ptr]      <= i_push_pc;
            next_pc_mem[tail_ptr] <= i_push_next_pc;
            instr_mem[tail_ptr]   <= i_push_instr;
        end
    end

    // head is registered, data shows up the cycle after the pop
    always_ff @(posedge clk) begin
        if (do_pop) begin
            o_head_pc      <= pc_mem[head_ptr];
            o_head_next_pc <= next_pc_mem[head_ptr];
            o_head_instr   <= instr_mem[head_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n || i_flush) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (do_push) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (do_pop) begin
                head_ptr <= head_ptr + 1'b1;
            end
            // push and pop together leave the count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (!i_rst_n) i_push |-> !o_full)
        else $error("i_queue: push while full");

    a_no_pop_empty: assert property (@(posedge clk) disable iff (!i_rst_n) i_pop |-> !o_empty)
        else $error("i_queue: pop while empty");

endmodule : i_queue

// ==== decode.sv ====
`timescale 1ns/10ps

module decode
    import fetch_pkg::*;
(
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_flush,
    // queue read side
    input  logic                 i_empty,
    output logic                 o_pop,
    input  logic [XLEN-1:0]      i_head_pc,
    input  logic [XLEN-1:0]      i_head_next_pc,
    input  logic [XLEN-1:0]      i_head_instr,
    // decoded output to issue
    input  logic                 i_dec_ready,
    output logic                 o_dec_valid,
    output logic [XLEN-1:0]      o_dec_pc,
    output logic [XLEN-1:0]      o_dec_next_pc,
    output logic [6:0]           o_dec_opcode,
    output logic [REG_IDX_W-1:0] o_dec_rd,
    output logic [REG_IDX_W-1:0] o_dec_rs1,
    output logic [REG_IDX_W-1:0] o_dec_rs2,
    output logic [2:0]           o_dec_funct3,
    output logic [6:0]           o_dec_funct7,
    output logic [XLEN-1:0]      o_dec_imm
);

    rv32i_instr_u    instr;
    logic            pending;
    logic            take;
    logic [XLEN-1:0] imm;

    assign instr = i_head_instr;
    assign take  = o_dec_valid && i_dec_ready;

    // pop only when the output will be free by the time the head arrives
    assign o_pop = !i_empty && !pending && (!o_dec_valid || i_dec_ready) && !i_flush;

    // immediate by format
    always_comb begin
        case (instr.r.opcode)
            OPC_LUI, OPC_AUIPC: begin
                imm = {instr.u.imm_31_12, 12'b0};
            end
            OPC_JAL: begin
                imm = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                       instr.j.imm_11, instr.j.imm_10_1, 1'b0};
            end
            OPC_JALR, OPC_LOAD, OPC_OPIMM: begin
                imm = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
            end
            OPC_STORE: begin
                imm = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
            end
            OPC_BRANCH: begin
                imm = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                       instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
            end
            // register type and unknown opcodes carry no immediate
            default: begin
                imm = '0;
            end
        endcase
    end

    // pending marks the cycle where the queue head is valid
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            pending     <= 1'b0;
            o_dec_valid <= 1'b0;
        end else if (i_flush) begin
            pending     <= 1'b0;
            o_dec_valid <= 1'b0;
        end else begin
            pending <= o_pop;
            if (pending) begin
                o_dec_valid <= 1'b1;
            end else if (take) begin
                o_dec_valid <= 1'b0;
            end
        end
    end

    // the pop rule keeps the output slot free whenever pending is set
    always_ff @(posedge clk) begin
        if (pending) begin
            o_dec_pc      <= i_head_pc;
            o_dec_next_pc <= i_head_next_pc;
            o_dec_opcode  <= instr.r.opcode;
            o_dec_rd      <= instr.r.rd;
            o_dec_rs1     <= instr.r.rs1;
            o_dec_rs2     <= instr.r.rs2;
            o_dec_funct3  <= instr.r.funct3;
            o_dec_funct7  <= instr.r.funct7;
            o_dec_imm     <= imm;
        end
    end

    // stalled output must not move until taken
    property p_hold_on_stall;
        @(posedge clk) disable iff (!i_rst_n)
            (o_dec_valid && !i_dec_ready && !i_flush) |=>
                (o_dec_valid && $stable(o_dec_pc) && $stable(o_dec_imm)
                 && $stable(o_dec_opcode) && $stable(o_dec_rd));
    endproperty

    a_hold_on_stall: assert property (p_hold_on_stall)
        else $error("decode: output changed while stalled");

endmodule : decode

// ==== fetch_frontend.sv ====
`timescale 1ns/10ps

module fetch_frontend
    import fetch_pkg::*;
(
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_flush,
    input  logic [XLEN-1:0]      i_redirect_pc,
    // wishbone classic master to instruction memory
    output logic                 o_wb_cyc,
    output logic                 o_wb_stb,
    output logic [XLEN-1:0]      o_wb_adr,
    output logic                 o_wb_we,
    output logic [3:0]           o_wb_sel,
    input  logic [XLEN-1:0]      i_wb_dat,
    input  logic                 i_wb_ack,
    // decoded instruction stream
    input  logic                 i_dec_ready,
    output logic                 o_dec_valid,
    output logic [XLEN-1:0]      o_dec_pc,
    output logic [XLEN-1:0]      o_dec_next_pc,
    output logic [6:0]           o_dec_opcode,
    output logic [REG_IDX_W-1:0] o_dec_rd,
    output logic [REG_IDX_W-1:0] o_dec_rs1,
    output logic [REG_IDX_W-1:0] o_dec_rs2,
    output logic [2:0]           o_dec_funct3,
    output logic [6:0]           o_dec_funct7,
    output logic [XLEN-1:0]      o_dec_imm
);

    // fetch to queue
    logic            push;
    logic [XLEN-1:0] push_pc;
    logic [XLEN-1:0] push_next_pc;
    logic [XLEN-1:0] push_instr;
    logic            full;

    // queue to decode
    logic            pop;
    logic            empty;
    logic [XLEN-1:0] head_pc;
    logic [XLEN-1:0] head_next_pc;
    logic [XLEN-1:0] head_instr;

    ifetch ifetch_i (
        .i_rst_n       (i_rst_n),
        .clk           (clk),
        .i_flush       (i_flush),
        .i_redirect_pc (i_redirect_pc),
        .i_wb_dat      (i_wb_dat),
        .i_wb_ack      (i_wb_ack),
        .o_wb_cyc      (o_wb_cyc),
        .o_wb_stb      (o_wb_stb),
        .o_wb_adr      (o_wb_adr),
        .o_wb_we       (o_wb_we),
        .o_wb_sel      (o_wb_sel),
        .i_full        (full),
        .o_push        (push),
        .o_push_pc     (push_pc),
        .o_push_next_pc(push_next_pc),
        .o_push_instr  (push_instr)
    );

    i_queue i_queue_i (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_flush       (i_flush),
        .i_push        (push),
        .i_push_pc     (push_pc),
        .i_push_next_pc(push_next_pc),
        .i_push_instr  (push_instr),
        .i_pop         (pop),
        .o_head_pc     (head_pc),
        .o_head_next_pc(head_next_pc),
        .o_head_instr  (head_instr),
        .o_empty       (empty),
        .o_full        (full)
    );

    decode decode_i (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_flush       (i_flush),
        .i_empty       (empty),
        .o_pop         (pop),
        .i_head_pc     (head_pc),
        .i_head_next_pc(head_next_pc),
        .i_head_instr  (head_instr),
        .i_dec_ready   (i_dec_ready),
        .o_dec_valid   (o_dec_valid),
        .o_dec_pc      (o_dec_pc),
        .o_dec_next_pc (o_dec_next_pc),
        .o_dec_opcode  (o_dec_opcode),
        .o_dec_rd      (o_dec_rd),
        .o_dec_rs1     (o_dec_rs1),
        .o_dec_rs2     (o_dec_rs2),
        .o_dec_funct3  (o_dec_funct3),
        .o_dec_funct7  (o_dec_funct7),
        .o_dec_imm     (o_dec_imm)
    );

endmodule : fetch_frontend

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
    output logic o_clk,
    output logic o_rst_n
);

    localparam realtime HALF_PERIOD  = 50.0;
    localparam int      RESET_CYCLES = 10;

    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

    // release just after an edge, like the other inputs
    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1;
        o_rst_n = 1'b1;
    end

endmodule : tb_clock_gen

// ==== tb_fetch_frontend.sv ====
`timescale 1ns/10ps

module tb_fetch_frontend
    import fetch_pkg::*;
();

    localparam int NUM_INSTR   = 600;
    localparam int CYCLE_LIMIT = 8 * NUM_INSTR + 200;
    localparam int MEM_WORDS   = 256;

    logic                 clk;
    logic                 rst_n;
    logic                 flush;
    logic [XLEN-1:0]      redirect_pc;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic [XLEN-1:0]      wb_adr;
    logic                 wb_we;
    logic [3:0]           wb_sel;
    logic [XLEN-1:0]      wb_dat;
    logic                 wb_ack;
    logic                 dec_ready;
    logic                 dec_valid;
    logic [XLEN-1:0]      dec_pc;
    logic [XLEN-1:0]      dec_next_pc;
    logic [6:0]           dec_opcode;
    logic [REG_IDX_W-1:0] dec_rd;
    logic [REG_IDX_W-1:0] dec_rs1;
    logic [REG_IDX_W-1:0] dec_rs2;
    logic [2:0]           dec_funct3;
    logic [6:0]           dec_funct7;
    logic [XLEN-1:0]      dec_imm;

    logic [XLEN-1:0] imem [MEM_WORDS];
    logic [31:0]     lfsr = 32'd87;
    logic [XLEN-1:0] exp_pc;
    rv32i_instr_u    word;
    logic            next_ack;
    logic [XLEN-1:0] next_dat;
    logic            next_ready;
    logic            next_flush;
    logic [XLEN-1:0] next_redirect;
    logic            req_active;
    logic            seen_full;
    logic            seen_post_flush;
    int              wait_cnt;
    int              stall_left;
    int              cycles;
    int              transfers;
    int              flushes;

    tb_clock_gen tb_clock_gen_i (
        .o_clk  (clk),
        .o_rst_n(rst_n)
    );

    fetch_frontend fetch_frontend_i (
        .clk(clk), .i_rst_n(rst_n), .i_flush(flush), .i_redirect_pc(redirect_pc),
        .o_wb_cyc(wb_cyc), .o_wb_stb(wb_stb), .o_wb_adr(wb_adr), .o_wb_we(wb_we),
        .o_wb_sel(wb_sel), .i_wb_dat(wb_dat), .i_wb_ack(wb_ack),
        .i_dec_ready(dec_ready), .o_dec_valid(dec_valid), .o_dec_pc(dec_pc),
        .o_dec_next_pc(dec_next_pc), .o_dec_opcode(dec_opcode), .o_dec_rd(dec_rd),
        .o_dec_rs1(dec_rs1), .o_dec_rs2(dec_rs2), .o_dec_funct3(dec_funct3),
        .o_dec_funct7(dec_funct7), .o_dec_imm(dec_imm)
    );

    // galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int k = 0; k < n; k++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return val;
    endfunction

    function automatic logic [6:0] pick_opcode(input logic [3:0] sel);
        case (sel % 9)
            0: return OPC_LUI;
            1: return OPC_AUIPC;
            2: return OPC_JAL;
            3: return OPC_JALR;
            4: return OPC_BRANCH;
            5: return OPC_LOAD;
            6: return OPC_STORE;
            7: return OPC_OPIMM;
            default: return OPC_OP;
        endcase
    endfunction

    // immediate straight from the isa bit positions
    function automatic logic [XLEN-1:0] ref_imm(input logic [31:0] w);
        case (w[6:0])
            OPC_LUI, OPC_AUIPC: return {w[31:12], 12'h000};
            OPC_JAL: return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            OPC_JALR, OPC_LOAD, OPC_OPIMM: return {{21{w[31]}}, w[30:20]};
            OPC_STORE: return {{21{w[31]}}, w[30:25], w[11:7]};
            OPC_BRANCH: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            default: return '0;
        endcase
    endfunction

    task automatic stop_on_failure();
        $display(">>> FAIL");
        $fatal(1, "run stopped after first error");
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_reg(input string name, input logic [REG_IDX_W-1:0] got,
                             input logic [REG_IDX_W-1:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_field(input string name, input logic [6:0] got,
                               input logic [6:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_bus();
        if (wb_stb && !wb_cyc) begin
            $display("wishbone stb is high while cyc is low");
            stop_on_failure();
        end
        if (wb_cyc) begin
            check_word("o_wb_adr[1:0]", XLEN'(wb_adr[1:0]), '0);
            check_field("o_wb_sel", 7'(wb_sel), 7'h0f);
            if (wb_we !== 1'b0) begin
                $display("wishbone write enable is high during an instruction fetch");
                stop_on_failure();
            end
        end
    endtask

    task automatic check_transfer();
        rv32i_instr_u w;
        w.raw = imem[exp_pc[9:2]];
        check_word("o_dec_pc", dec_pc, exp_pc);
        check_word("o_dec_next_pc", dec_next_pc, exp_pc + 32'd4);
        check_field("o_dec_opcode", dec_opcode, w.raw[6:0]);
        check_reg("o_dec_rd", dec_rd, w.raw[11:7]);
        check_reg("o_dec_rs1", dec_rs1, w.raw[19:15]);
        check_reg("o_dec_rs2", dec_rs2, w.raw[24:20]);
        check_field("o_dec_funct3", 7'(dec_funct3), 7'(w.raw[14:12]));
        check_field("o_dec_funct7", dec_funct7, w.raw[31:25]);
        check_word("o_dec_imm", dec_imm, ref_imm(w.raw));
        exp_pc = exp_pc + 32'd4;
    endtask

    // registered slave with 0 to 3 extra wait states per request
    task automatic answer_bus();
        if (flush || !wb_stb || wb_ack) begin
            next_ack   = 1'b0;
            req_active = 1'b0;
        end else begin
            if (!req_active) begin
                req_active = 1'b1;
                wait_cnt   = rand_bits(2);
            end
            if (wait_cnt == 0) begin
                next_ack = 1'b1;
                next_dat = imem[wb_adr[9:2]];
            end else begin
                next_ack = 1'b0;
                wait_cnt--;
            end
        end
    endtask

    task automatic choose_inputs();
        if (stall_left > 0) begin
            next_ready = 1'b0;
            stall_left--;
        end else if (rand_bits(6) == 0) begin
            next_ready = 1'b0;
            stall_left = 32 + rand_bits(5);
        end else begin
            next_ready = (rand_bits(2) != 0);
        end
        // rare single cycle flush pulses
        next_flush = !flush && (rand_bits(8) == 0);
        if (next_flush) begin
            next_redirect = {22'd0, 8'(rand_bits(8)), 2'b00};
        end
    endtask

    initial begin
        flush = 1'b0;
        redirect_pc = '0;
        wb_dat = '0;
        wb_ack = 1'b0;
        dec_ready = 1'b0;
        next_dat = '0;
        next_redirect = '0;
        req_active = 1'b0;
        seen_full = 1'b0;
        seen_post_flush = 1'b0;
        wait_cnt = 0;
        stall_left = 0;
        cycles = 0;
        transfers = 0;
        flushes = 0;
        exp_pc = RESET_PC;
        for (int idx = 0; idx < MEM_WORDS; idx++) begin
            word.raw      = rand_bits(32);
            word.r.opcode = pick_opcode(4'(rand_bits(4)));
            imem[idx]     = word.raw;
        end

        @(posedge rst_n);
        check_field("o_wb_cyc", 7'(wb_cyc), 7'h0);
        check_field("o_wb_stb", 7'(wb_stb), 7'h0);
        check_field("o_dec_valid", 7'(dec_valid), 7'h0);
        check_field("queue empty", 7'(fetch_frontend_i.empty), 7'h1);
        check_word("o_wb_adr", wb_adr, RESET_PC);

        while (transfers < NUM_INSTR) begin
            @(negedge clk);
            cycles++;
            if (cycles > CYCLE_LIMIT) begin
                $display("timeout: only %0d of %0d instructions decoded", transfers, NUM_INSTR);
                stop_on_failure();
            end
            check_bus();
            if (dec_valid && dec_ready) begin
                check_transfer();
                transfers++;
                if (flushes > 0) begin
                    seen_post_flush = 1'b1;
                end
            end
            if (flush) begin
                exp_pc = redirect_pc;
                flushes++;
            end
            if (fetch_frontend_i.full && !dec_ready) begin
                seen_full = 1'b1;
            end
            answer_bus();
            choose_inputs();
            @(posedge clk);
            #1;
            wb_ack      = next_ack;
            wb_dat      = next_dat;
            dec_ready   = next_ready;
            flush       = next_flush;
            redirect_pc = next_redirect;
        end

        if (seen_full && seen_post_flush) begin
            $display(">>> PASS");
            $finish;
        end else begin
            if (!seen_full) begin
                $display("the queue never filled while ready was held low");
            end
            if (!seen_post_flush) begin
                $display("no instruction was decoded after a flush");
            end
            stop_on_failure();
        end
    end

endmodule : tb_fetch_frontend

// ==== fetch_frontend.f ====
fetch_pkg.sv
ifetch.sv
i_queue.sv
decode.sv
fetch_frontend.sv
tb_clock_gen.sv
tb_fetch_frontend.sv
